// File: project.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/line_buffer.sv
rtl/window_3x3_datapath.sv
rtl/window_ctrl.sv
rtl/kernel_row_mac.sv
rtl/kernel_combine.sv
rtl/conv3x3_top.sv
testbench/tb_conv3x3.sv

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f project.f --top-module tb_conv3x3 -o sim_tb_conv3x3 > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_tb_conv3x3 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TB FAILED" "$SIM_LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// File: testbench/conv3x3_stimulus.txt
# per frame: "k code" (0 identity, 1 gauss, 2 sharpen, 3 edge),
# six "p" rows of 8 input pixels, four "e" rows of 6 expected outputs, decimal.

# frame 0, identity
k 0
p 12 34 56 78 90 123 145 167
p 200 1 2 3 4 5 6 255
p 17 250 128 64 32 16 8 9
p 99 88 77 66 55 44 33 22
p 0 255 0 255 0 255 0 255
p 11 22 33 44 55 66 77 88
e 1 2 3 4 5 6
e 250 128 64 32 16 8
e 88 77 66 55 44 33
e 255 0 255 0 255 0

# frame 1, gauss
k 1
p 0 16 32 48 64 80 96 112
p 255 255 255 255 0 0 0 0
p 100 90 80 70 60 50 40 30
p 7 13 200 3 9 250 1 17
p 40 40 40 40 40 40 40 40
p 255 0 255 0 255 0 255 0
e 154 155 125 62 32 34
e 123 129 96 62 56 36
e 61 82 54 58 86 53
e 66 77 65 68 83 68

# frame 2, sharpen
k 2
p 10 10 10 10 10 10 10 10
p 10 200 10 60 100 100 0 10
p 10 10 250 50 100 30 255 10
p 0 0 0 50 100 120 0 0
p 255 255 255 50 60 80 255 255
p 10 10 10 10 10 10 10 10
e 255 0 130 230 255 0
e 0 255 0 220 0 255
e 0 0 50 170 255 0
e 255 255 0 60 0 255

# frame 3, edge
k 3
p 0 0 0 0 0 0 0 0
p 0 255 0 100 100 100 20 0
p 0 0 0 100 200 100 40 0
p 50 50 50 100 100 100 60 0
p 50 50 50 50 50 50 80 255
p 50 50 50 50 50 50 100 255
e 255 255 200 0 180 60
e 255 150 0 255 40 20
e 50 0 100 50 90 20
e 0 0 50 50 80 145

// File: testbench/tb_conv3x3.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module tb_conv3x3;
  import conv_pkg::*;

  localparam int    NUM_FRAMES  = 4;
  localparam int    FRAME_PIX   = `CONV_COLS * `CONV_ROWS;
  localparam int    FRAME_OUT   = (`CONV_COLS - 2) * (`CONV_ROWS - 2);
  // at most four cycles per pixel plus reset and frame turnaround.
  localparam int    CYCLE_LIMIT = NUM_FRAMES * FRAME_PIX * 4 + 200;
  localparam string STIM_FILE   = "testbench/conv3x3_stimulus.txt";

  logic        clk;
  logic        rst_n;
  logic        start_i;
  kernel_e     kernel_sel_i;
  logic        pix_valid_i;
  pix_t        pix_i;
  logic        out_valid_o;
  pix_t        out_pix_o;
  logic        frame_done_o;

  int          kern_q[$];
  int          pix_q[$];
  int          exp_q[$];
  int          cycle_cnt;
  int          out_in_frame;
  int          frames_done;
  logic        frame_open;
  logic [31:0] rng;

  conv3x3_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .kernel_sel_i(kernel_sel_i),
    .pix_valid_i (pix_valid_i),
    .pix_i       (pix_i),
    .out_valid_o (out_valid_o),
    .out_pix_o   (out_pix_o),
    .frame_done_o(frame_done_o)
  );

  always #10 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] time %0t: %s is %0d, expected %0d",
                         $time, name, actual, expected));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // k lines hold a kernel code, p lines a pixel row, e lines an expected row.
  task automatic load_stimulus();
    int    fd;
    int    n;
    string line;
    int    v[8];
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_run({"could not open the stimulus file ", STIM_FILE});
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0) begin
        if ($sscanf(line, "k %d", v[0]) == 1) begin
          kern_q.push_back(v[0]);
        end else if ($sscanf(line, "p %d %d %d %d %d %d %d %d",
                             v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) == 8) begin
          for (int i = 0; i < 8; i++) begin
            pix_q.push_back(v[i]);
          end
        end else if ($sscanf(line, "e %d %d %d %d %d %d",
                             v[0], v[1], v[2], v[3], v[4], v[5]) == 6) begin
          for (int i = 0; i < 6; i++) begin
            exp_q.push_back(v[i]);
          end
        end
      end
    end
    $fclose(fd);
    check_val("stimulus frame count", kern_q.size(), NUM_FRAMES);
    check_val("stimulus pixel count", pix_q.size(), NUM_FRAMES * FRAME_PIX);
    check_val("stimulus expected count", exp_q.size(), NUM_FRAMES * FRAME_OUT);
  endtask

  // start pulse and then the frame's pixels with random idle gaps.
  task automatic send_frame(input int f);
    int gap;
    frame_open    = 1'b1;
    start_i      <= 1'b1;
    kernel_sel_i <= kernel_e'(kern_q[f]);
    @(posedge clk);
    start_i <= 1'b0;
    for (int i = 0; i < FRAME_PIX; i++) begin
      rng = lcg_next(rng);
      gap = int'(rng[31:30]);
      repeat (gap) begin
        pix_valid_i <= 1'b0;
        @(posedge clk);
      end
      pix_valid_i <= 1'b1;
      pix_i       <= pix_t'(pix_q[f * FRAME_PIX + i]);
      @(posedge clk);
    end
    pix_valid_i <= 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    start_i      = 1'b0;
    kernel_sel_i = KERN_IDENTITY;
    pix_valid_i  = 1'b0;
    pix_i        = '0;
    cycle_cnt    = 0;
    out_in_frame = 0;
    frames_done  = 0;
    frame_open   = 1'b0;
    rng          = 32'hf193;
    load_stimulus();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int f = 0; f < NUM_FRAMES; f++) begin
      send_frame(f);
      while (frames_done <= f) begin
        @(posedge clk);
      end
    end
    // idle tail catches stray outputs after the last frame.
    repeat (20) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output monitor and timeout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk) begin
    if (rst_n) begin
      if (out_valid_o) begin
        if (!frame_open) begin
          fail_run("out_valid_o was high while no frame was in progress");
        end
        if (exp_q.size() == 0) begin
          fail_run("out_valid_o was high with no expected pixel left");
        end
        check_val("out_pix_o", out_pix_o, exp_q.pop_front());
        out_in_frame++;
      end
      if (frame_done_o) begin
        if (!frame_open) begin
          fail_run("frame_done_o pulsed while no frame was in progress");
        end
        check_val("outputs per frame", out_in_frame, FRAME_OUT);
        out_in_frame = 0;
        frames_done++;
        frame_open = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout, the frames did not finish within %0d cycles",
                         CYCLE_LIMIT));
    end
  end

endmodule

// File: rtl/conv3x3_top.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module conv3x3_top
  import conv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start_i,
  input  kernel_e kernel_sel_i,
  input  logic    pix_valid_i,
  input  pix_t    pix_i,
  output logic    out_valid_o,
  output pix_t    out_pix_o,
  output logic    frame_done_o
);

  logic       lb_clear;
  logic       lb_valid;
  logic       lb_win_ready;
  pix_t       row0;
  pix_t       row1;
  pix_t       row2;
  logic       count_en;
  logic       reset_en;
  logic       win_valid;
  logic       col_eq_max;
  logic       row_eq_max;
  kernel_e    kernel_q;
  pix_t       win_tap [9];
  acc_t       part [3];
  logic [2:0] part_valid;

  line_buffer u_lb (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (lb_clear),
    .pix_valid_i(pix_valid_i),
    .pix_i      (pix_i),
    .row0_o     (row0),
    .row1_o     (row1),
    .row2_o     (row2),
    .valid_o    (lb_valid),
    .win_ready_o(lb_win_ready)
  );

  window_3x3_datapath #(
    .COLS(`CONV_COLS),
    .ROWS(`CONV_ROWS)
  ) u_win (
    .clk               (clk),
    .rst_n             (rst_n),
    .shift_en_i        (lb_valid),
    .count_en_i        (count_en),
    .reset_en_i        (reset_en),
    .s1_i              (row0),
    .s2_i              (row1),
    .s3_i              (row2),
    .tap1_o            (win_tap[0]),
    .tap2_o            (win_tap[1]),
    .tap3_o            (win_tap[2]),
    .tap4_o            (win_tap[3]),
    .tap5_o            (win_tap[4]),
    .tap6_o            (win_tap[5]),
    .tap7_o            (win_tap[6]),
    .tap8_o            (win_tap[7]),
    .tap9_o            (win_tap[8]),
    .win_valid_o       (win_valid),
    .col_eq_max_o      (col_eq_max),
    .col_ge_threshold_o(),
    .row_eq_max_o      (row_eq_max)
  );

  window_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .kernel_sel_i(kernel_sel_i),
    .lb_valid_i  (lb_valid),
    .win_ready_i (lb_win_ready),
    .col_eq_max_i(col_eq_max),
    .row_eq_max_i(row_eq_max),
    .out_valid_i (out_valid_o),
    .kernel_o    (kernel_q),
    .lb_clear_o  (lb_clear),
    .count_en_o  (count_en),
    .reset_en_o  (reset_en),
    .frame_done_o(frame_done_o)
  );

  // one MAC per window row.
  for (genvar k = 0; k < 3; k++) begin : g_row_mac
    kernel_row_mac #(
      .KROW(k)
    ) u_mac (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid_i (win_valid),
      .kernel_i(kernel_q),
      .a_i     (win_tap[3*k]),
      .b_i     (win_tap[3*k+1]),
      .c_i     (win_tap[3*k+2]),
      .part_o  (part[k]),
      .valid_o (part_valid[k])
    );
  end

  kernel_combine u_comb (
    .clk        (clk),
    .rst_n      (rst_n),
    .kernel_i   (kernel_q),
    .part0_i    (part[0]),
    .part1_i    (part[1]),
    .part2_i    (part[2]),
    .valid0_i   (part_valid[0]),
    .valid1_i   (part_valid[1]),
    .valid2_i   (part_valid[2]),
    .out_pix_o  (out_pix_o),
    .out_valid_o(out_valid_o)
  );

endmodule

// File: rtl/kernel_combine.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module kernel_combine
  import conv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  kernel_e kernel_i,
  input  acc_t    part0_i,
  input  acc_t    part1_i,
  input  acc_t    part2_i,
  input  logic    valid0_i,
  input  logic    valid1_i,
  input  logic    valid2_i,
  output pix_t    out_pix_o,
  output logic    out_valid_o
);

  // two guard bits, gauss total reaches 16 x 255.
  localparam int SUM_W   = `CONV_ACC_W + 2;
  localparam int PIX_MAX = (1 << `CONV_PIX_W) - 1;

  typedef logic signed [SUM_W-1:0] sum_t;

  sum_t sum;
  sum_t scaled;
  pix_t clamped;

  assign sum = sum_t'(part0_i) + sum_t'(part1_i) + sum_t'(part2_i);

  always_comb begin
    case (kernel_i)
      KERN_GAUSS: scaled = sum >>> 4;
      KERN_EDGE:  scaled = (sum < 0) ? -sum : sum;
      default:    scaled = sum;
    endcase
  end

  // saturate to pixel range.
  always_comb begin
    if (scaled < 0) begin
      clamped = '0;
    end else if (scaled > PIX_MAX) begin
      clamped = '1;
    end else begin
      clamped = scaled[`CONV_PIX_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid0_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid0_i) begin
      out_pix_o <= clamped;
    end
  end

  a_valids_agree: assert property (
    @(posedge clk) disable iff (!rst_n)
    (valid0_i == valid1_i) && (valid1_i == valid2_i)
  );

endmodule

// File: rtl/kernel_row_mac.sv
`timescale 1ns/1ps

module kernel_row_mac
  import conv_pkg::*;
#(
  parameter int KROW = 0
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    valid_i,
  input  kernel_e kernel_i,
  input  pix_t    a_i,
  input  pix_t    b_i,
  input  pix_t    c_i,
  output acc_t    part_o,
  output logic    valid_o
);

  logic signed [3:0] k_a;
  logic signed [3:0] k_b;
  logic signed [3:0] k_c;
  acc_t              prod_a;
  acc_t              prod_b;
  acc_t              prod_c;

  // centre row differs, outer rows are equal.
  always_comb begin
    k_a = 4'sd0;
    k_b = 4'sd0;
    k_c = 4'sd0;
    case (kernel_i)
      KERN_IDENTITY: begin
        if (KROW == 1) begin
          k_b = 4'sd1;
        end
      end
      KERN_GAUSS: begin
        k_a = (KROW == 1) ? 4'sd2 : 4'sd1;
        k_b = (KROW == 1) ? 4'sd4 : 4'sd2;
        k_c = (KROW == 1) ? 4'sd2 : 4'sd1;
      end
      KERN_SHARPEN: begin
        k_a = (KROW == 1) ? -4'sd1 : 4'sd0;
        k_b = (KROW == 1) ? 4'sd5 : -4'sd1;
        k_c = (KROW == 1) ? -4'sd1 : 4'sd0;
      end
      default: begin
        k_a = (KROW == 1) ? 4'sd1 : 4'sd0;
        k_b = (KROW == 1) ? -4'sd4 : 4'sd1;
        k_c = (KROW == 1) ? 4'sd1 : 4'sd0;
      end
    endcase
  end

  // pixels are unsigned, zero extend before the signed multiply.
  assign prod_a = acc_t'({1'b0, a_i}) * acc_t'(k_a);
  assign prod_b = acc_t'({1'b0, b_i}) * acc_t'(k_b);
  assign prod_c = acc_t'({1'b0, c_i}) * acc_t'(k_c);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      part_o <= prod_a + prod_b + prod_c;
    end
  end

endmodule

// File: rtl/window_ctrl.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module window_ctrl
  import conv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start_i,
  input  kernel_e kernel_sel_i,
  input  logic    lb_valid_i,
  input  logic    win_ready_i,
  input  logic    col_eq_max_i,
  input  logic    row_eq_max_i,
  input  logic    out_valid_i,
  output kernel_e kernel_o,
  output logic    lb_clear_o,
  output logic    count_en_o,
  output logic    reset_en_o,
  output logic    frame_done_o
);

  localparam int OUT_TOTAL = (`CONV_COLS - 2) * (`CONV_ROWS - 2);

  ctrl_state_e              state;
  kernel_e                  kernel_q;
  logic [2*`CONV_CNT_W-1:0] out_cnt;
  logic                     frame_start;
  logic                     last_out;

  assign frame_start = (state == IDLE) && start_i;
  assign last_out    = (state == DONE) && out_valid_i && (out_cnt == OUT_TOTAL - 1);

  assign kernel_o   = kernel_q;
  assign lb_clear_o = frame_start;
  assign reset_en_o = frame_start;
  assign count_en_o = (state == RUN) && lb_valid_i && win_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      kernel_q <= KERN_IDENTITY;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            kernel_q <= kernel_sel_i;
            state    <= FILL;
          end
        end
        // first pixel of the frame leaves the line buffer.
        FILL: begin
          if (lb_valid_i) begin
            state <= RUN;
          end
        end
        RUN: begin
          if (col_eq_max_i && row_eq_max_i) begin
            state <= DONE;
          end
        end
        // windows still in the MAC and combine stages.
        DONE: begin
          if (last_out) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_cnt      <= '0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= last_out;
      if (frame_start) begin
        out_cnt <= '0;
      end else if (out_valid_i) begin
        out_cnt <= out_cnt + 1'b1;
      end
    end
  end

  a_no_count_at_wrap: assert property (
    @(posedge clk) disable iff (!rst_n)
    count_en_o |-> !col_eq_max_i
  );

endmodule

// File: rtl/window_3x3_datapath.sv
`timescale 1ns/1ps

module window_3x3_datapath
  import conv_pkg::*;
#(
  parameter int COLS = 128,
  parameter int ROWS = 128
) (
  input  logic clk,
  input  logic rst_n,
  input  logic shift_en_i,
  input  logic count_en_i,
  input  logic reset_en_i,
  input  pix_t s1_i,
  input  pix_t s2_i,
  input  pix_t s3_i,
  output pix_t tap1_o,
  output pix_t tap2_o,
  output pix_t tap3_o,
  output pix_t tap4_o,
  output pix_t tap5_o,
  output pix_t tap6_o,
  output pix_t tap7_o,
  output pix_t tap8_o,
  output pix_t tap9_o,
  output logic win_valid_o,
  output logic col_eq_max_o,
  output logic col_ge_threshold_o,
  output logic row_eq_max_o
);

  cnt_t col_cnt;
  cnt_t row_cnt;
  logic shift_q;
  logic count_q;
  pix_t s1_dly;
  pix_t s2_dly;
  pix_t s3_dly;
  pix_t s1_win [3];
  pix_t s2_win [3];
  pix_t s3_win [3];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // window counters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
    end else if (reset_en_i || col_eq_max_o) begin
      col_cnt <= '0;
    end else if (count_en_i) begin
      col_cnt <= col_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt <= '0;
    end else if (reset_en_i) begin
      row_cnt <= '0;
    end else if (col_eq_max_o) begin
      row_cnt <= row_cnt + 1'b1;
    end
  end

  assign col_eq_max_o       = (col_cnt == cnt_t'(COLS - 2));
  assign col_ge_threshold_o = (col_cnt > 0);
  assign row_eq_max_o       = (row_cnt == cnt_t'(ROWS - 3));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tap shifters
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q     <= 1'b0;
      count_q     <= 1'b0;
      win_valid_o <= 1'b0;
    end else begin
      shift_q     <= shift_en_i;
      count_q     <= count_en_i;
      win_valid_o <= count_q;
    end
  end

  always_ff @(posedge clk) begin
    if (shift_en_i) begin
      s1_dly <= s1_i;
      s2_dly <= s2_i;
      s3_dly <= s3_i;
    end
  end

  // one window step per accepted pixel, a cycle behind the delay stage.
  always_ff @(posedge clk) begin
    if (shift_q) begin
      s1_win[0] <= s1_dly;
      s2_win[0] <= s2_dly;
      s3_win[0] <= s3_dly;
      for (int i = 1; i < 3; i++) begin
        s1_win[i] <= s1_win[i-1];
        s2_win[i] <= s2_win[i-1];
        s3_win[i] <= s3_win[i-1];
      end
    end
  end

  // oldest column first.
  assign tap1_o = s1_win[2];
  assign tap2_o = s1_win[1];
  assign tap3_o = s1_win[0];
  assign tap4_o = s2_win[2];
  assign tap5_o = s2_win[1];
  assign tap6_o = s2_win[0];
  assign tap7_o = s3_win[2];
  assign tap8_o = s3_win[1];
  assign tap9_o = s3_win[0];

endmodule

// File: rtl/line_buffer.sv
`timescale 1ns/1ps
`include "conv_params.svh"

module line_buffer
  import conv_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic clear_i,
  input  logic pix_valid_i,
  input  pix_t pix_i,
  output pix_t row0_o,
  output pix_t row1_o,
  output pix_t row2_o,
  output logic valid_o,
  output logic win_ready_o
);

  localparam int PTR_W = $clog2(`CONV_COLS);

  pix_t             mem1 [`CONV_COLS];
  pix_t             mem2 [`CONV_COLS];
  cnt_t             col_q;
  cnt_t             row_q;
  logic [PTR_W-1:0] wr_ptr;
  logic             accept;
  logic             col_last;

  // a pixel arriving with the clear belongs to no frame.
  assign accept   = pix_valid_i && !clear_i;
  assign col_last = (col_q == cnt_t'(`CONV_COLS - 1));
  assign wr_ptr   = col_q[PTR_W-1:0];

  // input position tracking.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      if (col_last) begin
        col_q <= '0;
        row_q <= (row_q == cnt_t'(`CONV_ROWS - 1)) ? '0 : row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o     <= 1'b0;
      win_ready_o <= 1'b0;
    end else begin
      valid_o     <= accept;
      win_ready_o <= accept && (row_q >= 2) && (col_q >= 2);
    end
  end

  // mem1 holds row r-1 and mem2 row r-2.
  always_ff @(posedge clk) begin
    if (accept) begin
      mem1[wr_ptr] <= pix_i;
      mem2[wr_ptr] <= mem1[wr_ptr];
      row0_o       <= mem2[wr_ptr];
      row1_o       <= mem1[wr_ptr];
      row2_o       <= pix_i;
    end
  end

  a_no_window_after_clear: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(clear_i, 2) |-> !win_ready_o
  );

endmodule

// File: rtl/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

  typedef logic [`CONV_PIX_W-1:0] pix_t;

  // partial and total sums, signed.
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  typedef logic [`CONV_CNT_W-1:0] cnt_t;

  // codes match the stimulus file.
  typedef enum logic [1:0] {
    KERN_IDENTITY = 2'd0,
    KERN_GAUSS    = 2'd1,
    KERN_SHARPEN  = 2'd2,
    KERN_EDGE     = 2'd3
  } kernel_e;

  typedef enum logic [1:0] {
    IDLE,
    FILL,
    RUN,
    DONE
  } ctrl_state_e;

endpackage

// File: rtl/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// frame geometry.
`define CONV_COLS 8
`define CONV_ROWS 6

// datapath widths.
`define CONV_PIX_W 8
`define CONV_ACC_W 12

// row and column counters.
`define CONV_CNT_W 10

`endif
